// ==== verilog/mac_client_pkg.sv ====
package mac_client_pkg;

  //////////////////////////////
  // lane geometry
  //////////////////////////////
  localparam int BYTE_W = 8;                 // one byte lane
  localparam int KEEP_W = 8;                 // byte lanes per client word
  localparam int DATA_W = BYTE_W * KEEP_W;   // 64-bit client word

  //////////////////////////////
  // receive buffer
  //////////////////////////////
  localparam int RX_BUF_AW    = 9;                 // byte address bits
  localparam int RX_BUF_DEPTH = 1 << RX_BUF_AW;    // 512 bytes

  typedef logic [BYTE_W-1:0]          byte_t;    // one byte
  typedef logic [DATA_W-1:0]          word_t;    // lane 0 in bits 7:0
  typedef logic [KEEP_W-1:0]          keep_t;    // one enable per lane
  typedef logic [$clog2(KEEP_W)-1:0]  lane_t;    // lane index 0..7
  typedef logic [RX_BUF_AW:0]         rx_ptr_t;  // extra wrap bit for full/empty

  // filter write side
  typedef enum logic {
    RX_STORE,    // bytes go into the buffer
    RX_DISCARD   // overflowed frame, swallow until its last byte
  } rx_state_t;

  // downsizer
  typedef enum logic {
    TX_IDLE,     // ready for a new word
    TX_SEND      // walking lanes of the held word
  } tx_state_t;

endpackage

// ==== verilog/rx_frame_filter.sv ====
`timescale 1ns/1ps

module rx_frame_filter (
  input  logic                  clk_125,
  input  logic                  rst_n,
  input  mac_client_pkg::byte_t rx_axis_mac_tdata,
  input  logic                  rx_axis_mac_tvalid,
  input  logic                  rx_axis_mac_tlast,
  input  logic                  rx_axis_mac_tuser,
  input  logic                  flt_ready,
  output mac_client_pkg::byte_t flt_byte,
  output logic                  flt_last,
  output logic                  flt_valid,
  output logic                  rx_frame_drop
);
  import mac_client_pkg::*;

  logic [BYTE_W:0] buf_mem [RX_BUF_DEPTH];  // {last, data} per byte

  rx_state_t state;       // write side mode
  rx_ptr_t   wr_ptr;      // next free slot
  rx_ptr_t   cmt_ptr;     // end of last good frame
  rx_ptr_t   rd_ptr;      // next byte to stream out
  logic      buf_full;    // write would overrun unread bytes
  logic      buf_write;   // byte lands in the buffer
  logic      rd_avail;    // committed bytes waiting
  logic      rd_load;     // output register takes next byte

  // full against the read pointer, space frees as bytes leave
  assign buf_full  = (wr_ptr[RX_BUF_AW] != rd_ptr[RX_BUF_AW]) &&
                     (wr_ptr[RX_BUF_AW-1:0] == rd_ptr[RX_BUF_AW-1:0]);
  assign buf_write = rx_axis_mac_tvalid && (state == RX_STORE) && !buf_full;
  assign rd_avail  = (cmt_ptr != rd_ptr);                  // only committed bytes
  assign rd_load   = rd_avail && (!flt_valid || flt_ready); // slot empty or draining

  //////////////////////////////
  // write side
  //////////////////////////////
  always_ff @(posedge clk_125)
  begin
    if (buf_write)
    begin
      buf_mem[wr_ptr[RX_BUF_AW-1:0]] <= {rx_axis_mac_tlast, rx_axis_mac_tdata};
    end
  end

  always_ff @(posedge clk_125 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= RX_STORE;
      wr_ptr        <= '0;
      cmt_ptr       <= '0;
      rx_frame_drop <= 1'b0;
    end
    else
    begin
      rx_frame_drop <= 1'b0;                       // single cycle pulse
      if (rx_axis_mac_tvalid)
      begin
        if (state == RX_DISCARD)
        begin
          if (rx_axis_mac_tlast)                   // end of the overflowed frame
          begin
            state         <= RX_STORE;
            rx_frame_drop <= 1'b1;
          end
        end
        else if (buf_full)
        begin
          wr_ptr <= cmt_ptr;                       // throw away partial frame
          if (rx_axis_mac_tlast)
            rx_frame_drop <= 1'b1;                 // overflow on the final byte
          else
            state <= RX_DISCARD;                   // drop the rest of it
        end
        else if (rx_axis_mac_tlast && rx_axis_mac_tuser)
        begin
          wr_ptr        <= cmt_ptr;                // bad fcs or similar, rewind
          rx_frame_drop <= 1'b1;
        end
        else if (rx_axis_mac_tlast)
        begin
          wr_ptr  <= wr_ptr + 1'b1;
          cmt_ptr <= wr_ptr + 1'b1;                // frame now visible to reader
        end
        else
        begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////
  always_ff @(posedge clk_125 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_ptr    <= '0;
      flt_valid <= 1'b0;
    end
    else if (rd_load)
    begin
      rd_ptr    <= rd_ptr + 1'b1;
      flt_valid <= 1'b1;
    end
    else if (flt_ready)
    begin
      flt_valid <= 1'b0;                           // last byte taken, nothing behind
    end
  end

  always_ff @(posedge clk_125)
  begin
    if (rd_load)
    begin
      {flt_last, flt_byte} <= buf_mem[rd_ptr[RX_BUF_AW-1:0]];  // registered read
    end
  end

endmodule

// ==== verilog/rx_width_upsizer.sv ====
`timescale 1ns/1ps

module rx_width_upsizer (
  input  logic                  clk_125,
  input  logic                  rst_n,
  input  mac_client_pkg::byte_t flt_byte,
  input  logic                  flt_last,
  input  logic                  flt_valid,
  input  logic                  mac_rx_ready,
  output logic                  flt_ready,
  output mac_client_pkg::word_t mac_rx_data,
  output mac_client_pkg::keep_t mac_rx_keep,
  output logic                  mac_rx_last,
  output logic                  mac_rx_valid
);
  import mac_client_pkg::*;

  lane_t lane;        // lane the next byte goes to
  logic  byte_fire;   // byte accepted from the filter
  logic  word_take;   // client takes the finished word
  logic  word_done;   // this byte closes the word

  // stall only while a finished word is still sitting there
  assign flt_ready = !mac_rx_valid || mac_rx_ready;
  assign byte_fire = flt_valid && flt_ready;
  assign word_take = mac_rx_valid && mac_rx_ready;
  assign word_done = byte_fire && (flt_last || (lane == lane_t'(KEEP_W-1)));

  //////////////////////////////
  // lane count and handshake
  //////////////////////////////
  always_ff @(posedge clk_125 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lane         <= '0;
      mac_rx_keep  <= '0;
      mac_rx_last  <= 1'b0;
      mac_rx_valid <= 1'b0;
    end
    else
    begin
      if (word_take)
        mac_rx_valid <= 1'b0;                      // may be set again below
      if (byte_fire)
      begin
        if (lane == '0)
          mac_rx_keep <= keep_t'(1);               // fresh word, lane 0 only
        else
          mac_rx_keep <= mac_rx_keep | (keep_t'(1) << lane);
        if (word_done)
        begin
          lane         <= '0;
          mac_rx_valid <= 1'b1;                    // present on the next clock
          mac_rx_last  <= flt_last;
        end
        else
        begin
          lane <= lane + 1'b1;
        end
      end
    end
  end

  // byte lands in its lane, earliest byte in bits 7:0
  always_ff @(posedge clk_125)
  begin
    if (byte_fire)
    begin
      mac_rx_data[lane*BYTE_W +: BYTE_W] <= flt_byte;
    end
  end

endmodule

// ==== verilog/tx_width_downsizer.sv ====
`timescale 1ns/1ps

module tx_width_downsizer (
  input  logic                  clk_125,
  input  logic                  rst_n,
  input  mac_client_pkg::word_t mac_tx_data,
  input  mac_client_pkg::keep_t mac_tx_keep,
  input  logic                  mac_tx_last,
  input  logic                  mac_tx_valid,
  input  logic                  tx_axis_mac_tready,
  output logic                  mac_tx_ready,
  output mac_client_pkg::byte_t tx_axis_mac_tdata,
  output logic                  tx_axis_mac_tvalid,
  output logic                  tx_axis_mac_tlast
);
  import mac_client_pkg::*;

  tx_state_t state;
  word_t     data_q;      // held client word
  keep_t     keep_q;      // its lane enables
  logic      last_q;      // word closes a frame
  lane_t     lane;        // lane on the byte bus now
  logic      byte_take;   // MAC accepts current byte
  logic      final_lane;  // no kept lane after this one

  assign mac_tx_ready       = (state == TX_IDLE);
  assign tx_axis_mac_tvalid = (state == TX_SEND);
  assign tx_axis_mac_tdata  = data_q[lane*BYTE_W +: BYTE_W];
  assign byte_take          = tx_axis_mac_tvalid && tx_axis_mac_tready;
  assign final_lane         = (lane == lane_t'(KEEP_W-1)) ||
                              !keep_q[lane_t'(lane + 1'b1)];  // keep is contiguous
  assign tx_axis_mac_tlast  = tx_axis_mac_tvalid && last_q && final_lane;

  //////////////////////////////
  // lane walk FSM
  //////////////////////////////
  always_ff @(posedge clk_125 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= TX_IDLE;
      lane  <= '0;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (mac_tx_valid)
          begin
            state <= TX_SEND;                      // first byte out next clock
            lane  <= '0;
          end
        end
        TX_SEND:
        begin
          if (byte_take)
          begin
            if (final_lane)
              state <= TX_IDLE;                    // word done
            else
              lane <= lane + 1'b1;
          end
        end
      endcase
    end
  end

  // latch the word on acceptance
  always_ff @(posedge clk_125)
  begin
    if (mac_tx_valid && mac_tx_ready)
    begin
      data_q <= mac_tx_data;
      keep_q <= mac_tx_keep;
      last_q <= mac_tx_last;
    end
  end

endmodule

// ==== verilog/mac_client_bridge.sv ====
`timescale 1ns/1ps

module mac_client_bridge (
  input  logic                  clk_125,
  input  logic                  rst_n,
  // MAC receive bytes
  input  mac_client_pkg::byte_t rx_axis_mac_tdata,
  input  logic                  rx_axis_mac_tvalid,
  input  logic                  rx_axis_mac_tlast,
  input  logic                  rx_axis_mac_tuser,
  // client receive words
  output mac_client_pkg::word_t mac_rx_data,
  output mac_client_pkg::keep_t mac_rx_keep,
  output logic                  mac_rx_last,
  output logic                  mac_rx_valid,
  input  logic                  mac_rx_ready,
  output logic                  rx_frame_drop,
  // client transmit words
  input  mac_client_pkg::word_t mac_tx_data,
  input  mac_client_pkg::keep_t mac_tx_keep,
  input  logic                  mac_tx_last,
  input  logic                  mac_tx_valid,
  output logic                  mac_tx_ready,
  // MAC transmit bytes
  output mac_client_pkg::byte_t tx_axis_mac_tdata,
  output logic                  tx_axis_mac_tvalid,
  output logic                  tx_axis_mac_tlast,
  input  logic                  tx_axis_mac_tready
);
  import mac_client_pkg::*;

  byte_t flt_byte;    // good-frame bytes out of the buffer
  logic  flt_last;
  logic  flt_valid;
  logic  flt_ready;

  rx_frame_filter u_rx_frame_filter (
    .clk_125            (clk_125),
    .rst_n              (rst_n),
    .rx_axis_mac_tdata  (rx_axis_mac_tdata),
    .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
    .rx_axis_mac_tlast  (rx_axis_mac_tlast),
    .rx_axis_mac_tuser  (rx_axis_mac_tuser),   // bad frame flag on last byte
    .flt_ready          (flt_ready),
    .flt_byte           (flt_byte),
    .flt_last           (flt_last),
    .flt_valid          (flt_valid),
    .rx_frame_drop      (rx_frame_drop)
  );

  rx_width_upsizer u_rx_width_upsizer (
    .clk_125      (clk_125),
    .rst_n        (rst_n),
    .flt_byte     (flt_byte),
    .flt_last     (flt_last),
    .flt_valid    (flt_valid),
    .mac_rx_ready (mac_rx_ready),
    .flt_ready    (flt_ready),                 // back-pressure into the buffer
    .mac_rx_data  (mac_rx_data),
    .mac_rx_keep  (mac_rx_keep),
    .mac_rx_last  (mac_rx_last),
    .mac_rx_valid (mac_rx_valid)
  );

  tx_width_downsizer u_tx_width_downsizer (
    .clk_125            (clk_125),
    .rst_n              (rst_n),
    .mac_tx_data        (mac_tx_data),
    .mac_tx_keep        (mac_tx_keep),
    .mac_tx_last        (mac_tx_last),
    .mac_tx_valid       (mac_tx_valid),
    .tx_axis_mac_tready (tx_axis_mac_tready),
    .mac_tx_ready       (mac_tx_ready),
    .tx_axis_mac_tdata  (tx_axis_mac_tdata),
    .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
    .tx_axis_mac_tlast  (tx_axis_mac_tlast)
  );

endmodule

// ==== tb/mac_client_bridge_properties.sv ====
`timescale 1ns/1ps

module mac_client_bridge_properties (
  input logic                  clk_125,
  input logic                  rst_n,
  input mac_client_pkg::word_t mac_rx_data,
  input mac_client_pkg::keep_t mac_rx_keep,
  input logic                  mac_rx_last,
  input logic                  mac_rx_valid,
  input logic                  mac_rx_ready,
  input logic                  rx_frame_drop,
  input mac_client_pkg::byte_t tx_axis_mac_tdata,
  input logic                  tx_axis_mac_tvalid,
  input logic                  tx_axis_mac_tlast,
  input logic                  tx_axis_mac_tready
);
  import mac_client_pkg::*;

  word_t rx_kept;         // unkept lanes forced to zero
  int    fail_count = 0;  // assertion failures so far

  always_comb
  begin
    for (int i = 0; i < KEEP_W; i++)
      rx_kept[i*BYTE_W +: BYTE_W] = mac_rx_keep[i] ? mac_rx_data[i*BYTE_W +: BYTE_W] : '0;
  end

  rx_hold_a: assert property (@(posedge clk_125) disable iff (!rst_n)
    mac_rx_valid && !mac_rx_ready |=> mac_rx_valid && $stable(rx_kept) &&
                                      $stable(mac_rx_keep) && $stable(mac_rx_last))
    else
    begin
      $error("receive word dropped or changed while stalled");
      fail_count++;
    end

  tx_hold_a: assert property (@(posedge clk_125) disable iff (!rst_n)
    tx_axis_mac_tvalid && !tx_axis_mac_tready |=> tx_axis_mac_tvalid &&
                                                  $stable(tx_axis_mac_tdata) &&
                                                  $stable(tx_axis_mac_tlast))
    else
    begin
      $error("transmit byte dropped or changed while stalled");
      fail_count++;
    end

  // nonzero, and keep+1 a power of two
  rx_keep_a: assert property (@(posedge clk_125) disable iff (!rst_n)
    mac_rx_valid |-> (mac_rx_keep != '0) && ((mac_rx_keep & (mac_rx_keep + 1'b1)) == '0))
    else
    begin
      $error("receive keep not contiguous from lane 0");
      fail_count++;
    end

  drop_pulse_a: assert property (@(posedge clk_125) disable iff (!rst_n)
    rx_frame_drop |=> !rx_frame_drop)
    else
    begin
      $error("frame drop high on two cycles in a row");
      fail_count++;
    end

endmodule

// ==== tb/tb_mac_client_bridge.sv ====
`timescale 1ns/1ps

module tb_mac_client_bridge;
  import mac_client_pkg::*;

  logic  clk_125 = 1'b0;
  logic  rst_n;
  byte_t rx_axis_mac_tdata;
  logic  rx_axis_mac_tvalid, rx_axis_mac_tlast, rx_axis_mac_tuser;
  word_t mac_rx_data;
  keep_t mac_rx_keep;
  logic  mac_rx_last, mac_rx_valid, mac_rx_ready, rx_frame_drop;
  word_t mac_tx_data;
  keep_t mac_tx_keep;
  logic  mac_tx_last, mac_tx_valid, mac_tx_ready;
  byte_t tx_axis_mac_tdata;
  logic  tx_axis_mac_tvalid, tx_axis_mac_tlast, tx_axis_mac_tready;

  byte_t       exp_rx_byte[$];        // good-frame bytes in arrival order
  bit          exp_rx_last[$];        // frame end marker per byte
  byte_t       exp_tx_byte[$];        // kept lanes in lane order
  bit          exp_tx_last[$];
  int          drop_count = 0;        // pulses seen
  int          exp_drop_count = 0;    // frames sent to be discarded
  int          bytes_driven = 0;      // feeds the watchdog budget
  int          wd_cycles = 0;
  bit          rx_ready_hold = 1'b0;  // force client stall

  mac_client_bridge dut_i (.*);

  bind mac_client_bridge mac_client_bridge_properties props_i (.*);

  always #10 clk_125 = ~clk_125;      // 50 MHz sim clock, 20 ns

  // random back-pressure on both outputs
  always @(negedge clk_125)
  begin
    mac_rx_ready       = !rx_ready_hold && ($urandom_range(3, 0) != 0);
    tx_axis_mac_tready = ($urandom_range(3, 0) != 0);
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  //////////////////////////////
  // monitors
  //////////////////////////////
  task automatic check_rx_word();
    word_t exp_data;
    word_t mask;
    keep_t exp_keep;
    bit    exp_last;
    int    n;
    exp_data = '0;
    mask     = '0;
    exp_keep = '0;
    exp_last = 1'b0;
    n        = 0;
    // close on lane 7 or on the frame's last byte
    while (!exp_last && n < KEEP_W && exp_rx_byte.size() != 0)
    begin
      exp_data[n*BYTE_W +: BYTE_W] = exp_rx_byte.pop_front();  // lane 0 first
      mask[n*BYTE_W +: BYTE_W]     = '1;
      exp_last                     = exp_rx_last.pop_front();
      exp_keep[n]                  = 1'b1;
      n++;
    end
    assert (n != 0) else report_failure("A receive word arrived with no expected bytes left");
    assert (mac_rx_keep == exp_keep) else report_failure($sformatf(
      "Mismatch mac_rx_keep: expected 0x%h got 0x%h", exp_keep, mac_rx_keep));
    assert ((mac_rx_data & mask) == exp_data) else report_failure($sformatf(
      "Mismatch mac_rx_data: expected 0x%h got 0x%h", exp_data, mac_rx_data & mask));
    assert (mac_rx_last == exp_last) else report_failure($sformatf(
      "Mismatch mac_rx_last: expected 0x%h got 0x%h", exp_last, mac_rx_last));
  endtask

  task automatic check_tx_byte();
    byte_t exp_b;
    bit    exp_l;
    assert (exp_tx_byte.size() != 0) else report_failure("A transmit byte arrived unexpectedly");
    exp_b = exp_tx_byte.pop_front();
    exp_l = exp_tx_last.pop_front();
    assert (tx_axis_mac_tdata == exp_b) else report_failure($sformatf(
      "Mismatch tx_axis_mac_tdata: expected 0x%h got 0x%h", exp_b, tx_axis_mac_tdata));
    assert (tx_axis_mac_tlast == exp_l) else report_failure($sformatf(
      "Mismatch tx_axis_mac_tlast: expected 0x%h got 0x%h", exp_l, tx_axis_mac_tlast));
  endtask

  always @(posedge clk_125)
  begin
    if (rst_n && mac_rx_valid && mac_rx_ready)
      check_rx_word();                // word taken by client
    if (rst_n && tx_axis_mac_tvalid && tx_axis_mac_tready)
      check_tx_byte();                // byte taken by MAC
    if (rst_n && rx_frame_drop)
      drop_count++;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic send_rx_frame(input int len, input bit user_err, input bit deliver);
    byte_t b;
    for (int i = 0; i < len; i++)
    begin
      @(negedge clk_125);
      b                  = byte_t'($urandom);
      rx_axis_mac_tdata  = b;
      rx_axis_mac_tvalid = 1'b1;
      rx_axis_mac_tlast  = (i == len - 1);
      rx_axis_mac_tuser  = user_err && (i == len - 1);  // only meaningful with tlast
      bytes_driven++;
      if (deliver)
      begin
        exp_rx_byte.push_back(b);
        exp_rx_last.push_back(i == len - 1);
      end
    end
    if (!deliver)
      exp_drop_count++;
    @(negedge clk_125);
    rx_axis_mac_tvalid = 1'b0;
    rx_axis_mac_tlast  = 1'b0;
    rx_axis_mac_tuser  = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge clk_125);  // idle gap
  endtask

  task automatic send_tx_word(input int n_bytes, input bit last);
    word_t d;
    d = {$urandom, $urandom};
    @(negedge clk_125);
    mac_tx_data  = d;
    mac_tx_keep  = keep_t'((1 << n_bytes) - 1);        // contiguous from lane 0
    mac_tx_last  = last;
    mac_tx_valid = 1'b1;
    for (int i = 0; i < n_bytes; i++)
    begin
      exp_tx_byte.push_back(d[i*BYTE_W +: BYTE_W]);
      exp_tx_last.push_back(last && (i == n_bytes - 1));
    end
    bytes_driven += n_bytes;
    do
      @(posedge clk_125);
    while (!mac_tx_ready);            // handshake seen at this edge
    @(negedge clk_125);
    mac_tx_valid = 1'b0;
  endtask

  task automatic send_tx_burst(input int n_words);
    for (int i = 0; i < n_words; i++)
      send_tx_word($urandom_range(KEEP_W, 1), (i % 3 == 2) || (i == n_words - 1));
  endtask

  task automatic wait_rx_drained();
    while (exp_rx_byte.size() != 0)
      @(negedge clk_125);
    repeat (3) @(negedge clk_125);    // let a late drop pulse land
    assert (drop_count == exp_drop_count) else report_failure($sformatf(
      "Mismatch rx_frame_drop count: expected 0x%h got 0x%h", exp_drop_count, drop_count));
  endtask

  task automatic wait_tx_drained();
    while (exp_tx_byte.size() != 0)
      @(negedge clk_125);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic test_reset_values();
    @(negedge clk_125);
    assert (!mac_rx_valid) else report_failure($sformatf(
      "Mismatch mac_rx_valid: expected 0x0 got 0x%h", mac_rx_valid));
    assert (!tx_axis_mac_tvalid) else report_failure($sformatf(
      "Mismatch tx_axis_mac_tvalid: expected 0x0 got 0x%h", tx_axis_mac_tvalid));
    assert (!rx_frame_drop) else report_failure($sformatf(
      "Mismatch rx_frame_drop: expected 0x0 got 0x%h", rx_frame_drop));
    assert (mac_tx_ready) else report_failure($sformatf(
      "Mismatch mac_tx_ready: expected 0x1 got 0x%h", mac_tx_ready));
  endtask

  task automatic test_rx_good_frames();
    repeat (10) send_rx_frame($urandom_range(40, 1), 1'b0, 1'b1);  // fits in the buffer
    wait_rx_drained();
  endtask

  task automatic test_rx_bad_frame();
    send_rx_frame($urandom_range(40, 1), 1'b0, 1'b1);
    send_rx_frame($urandom_range(40, 1), 1'b1, 1'b0);  // tuser on last byte
    send_rx_frame($urandom_range(40, 1), 1'b0, 1'b1);
    wait_rx_drained();
  endtask

  task automatic test_rx_overflow();
    rx_ready_hold = 1'b1;
    send_rx_frame(RX_BUF_DEPTH + 64, 1'b0, 1'b0);      // cannot fit
    send_rx_frame(20, 1'b0, 1'b1);
    repeat (20) @(negedge clk_125);
    assert (mac_rx_valid) else report_failure(
      "No receive word was waiting while mac_rx_ready was held low");
    rx_ready_hold = 1'b0;
    wait_rx_drained();
  endtask

  task automatic test_tx_words();
    send_tx_burst(16);
    wait_tx_drained();
  endtask

  task automatic test_concurrent();
    fork
      repeat (8) send_rx_frame($urandom_range(40, 1), 1'b0, 1'b1);
      send_tx_burst(12);
    join
    wait_rx_drained();
    wait_tx_drained();
  endtask

  // budget grows with every byte driven
  initial
  begin
    forever
    begin
      @(posedge clk_125);
      wd_cycles++;
      if (wd_cycles > 2000 + 40 * bytes_driven)
        report_failure("Timeout: the tests did not finish within the cycle budget");
    end
  end

  initial
  begin
    void'($urandom(92645));
    rst_n              = 1'b0;
    rx_axis_mac_tdata  = '0;
    rx_axis_mac_tvalid = 1'b0;
    rx_axis_mac_tlast  = 1'b0;
    rx_axis_mac_tuser  = 1'b0;
    mac_rx_ready       = 1'b0;
    mac_tx_data        = '0;
    mac_tx_keep        = '0;
    mac_tx_last        = 1'b0;
    mac_tx_valid       = 1'b0;
    tx_axis_mac_tready = 1'b0;
    repeat (3) @(posedge clk_125);
    @(negedge clk_125);
    rst_n = 1'b1;
    test_reset_values();
    test_rx_good_frames();
    test_rx_bad_frame();
    test_rx_overflow();
    test_tx_words();
    test_concurrent();
    if (dut_i.props_i.fail_count == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "bound assertions failed during the run");
    end
  end

endmodule

// ==== tb.f ====
verilog/mac_client_pkg.sv
verilog/rx_frame_filter.sv
verilog/rx_width_upsizer.sv
verilog/tx_width_downsizer.sv
verilog/mac_client_bridge.sv
tb/mac_client_bridge_properties.sv
tb/tb_mac_client_bridge.sv

// ==== Bender.yml ====
package:
  name: mac_client_bridge

sources:
  - verilog/mac_client_pkg.sv
  - verilog/rx_frame_filter.sv
  - verilog/rx_width_upsizer.sv
  - verilog/tx_width_downsizer.sv
  - verilog/mac_client_bridge.sv
  - target: test
    files:
      - tb/mac_client_bridge_properties.sv
      - tb/tb_mac_client_bridge.sv
